/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// load type, anything but LOAD_NONE is a load
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_type_e;

	// store type, anything but STORE_NONE is a store
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_type_e;

	// request from the execute stage
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		load_type_e  load_type;
		store_type_e store_type;
		logic [4:0]  rd;
	} lsu_req_t;

	// result towards writeback
	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] wdata;
		logic        is_mem;
		logic        err;
	} lsu_wb_t;

endpackage

`default_nettype wire

/* verilog/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

	// response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// transfer size code for 4 bytes
	localparam logic [2:0] SIZE_WORD = 3'b010;

	// shared by the ar and aw channels
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_addr_t;

	// w channel payload
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axi_wdata_t;

	// r channel payload
	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axi_rdata_t;

endpackage

`default_nettype wire

/* verilog/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl
	import lsu_pkg::*, axi_lite_pkg::*;
(
	input  wire logic        clock,
	input  wire logic        rstn,
	input  wire logic        req_valid_i,
	input  wire lsu_req_t    req_i,
	input  wire axi_wdata_t  store_beat_i,
	input  wire logic [31:0] load_word_i,
	input  wire logic        ar_ready_i,
	input  wire logic        aw_ready_i,
	input  wire logic        w_ready_i,
	input  wire logic        r_valid_i,
	input  wire axi_rdata_t  r_i,
	input  wire logic        b_valid_i,
	input  wire logic [1:0]  b_resp_i,
	output logic             done_o,
	output lsu_wb_t          wb_o,
	output lsu_req_t         req_o,
	output logic             ar_valid_o,
	output axi_addr_t        ar_o,
	output logic             aw_valid_o,
	output axi_addr_t        aw_o,
	output logic             w_valid_o,
	output axi_wdata_t       w_o,
	output logic             r_ready_o,
	output logic             b_ready_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_RESP,
		ST_DONE
	} state_e;

	state_e      state_q;
	lsu_req_t    req_q;
	logic        aw_done_q;
	logic        w_done_q;
	logic        err_q;
	logic [31:0] load_q;
	logic        is_load;
	logic        is_store;
	logic        aw_fire;
	logic        w_fire;
	logic        r_fire;
	logic        b_fire;

	// a load wins if both types are set
	assign is_load  = (req_q.load_type != LOAD_NONE);
	assign is_store = (req_q.store_type != STORE_NONE) && !is_load;

	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire  = w_valid_o && w_ready_i;
	assign r_fire  = r_valid_i && r_ready_o;
	assign b_fire  = b_valid_i && b_ready_o;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= ST_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					aw_done_q <= 1'b0;
					w_done_q  <= 1'b0;
					if (req_valid_i) begin
						if (req_i.load_type != LOAD_NONE || req_i.store_type != STORE_NONE)
							state_q <= ST_ADDR;
						else
							state_q <= ST_DONE;
					end
				end
				ST_ADDR: begin
					if (is_load) begin
						if (ar_valid_o && ar_ready_i)
							state_q <= ST_RESP;
					end else begin
						// aw and w may complete in different cycles
						if (aw_fire)
							aw_done_q <= 1'b1;
						if (w_fire)
							w_done_q <= 1'b1;
						if ((aw_done_q || aw_fire) && (w_done_q || w_fire))
							state_q <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (r_fire || b_fire)
						state_q <= ST_DONE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// request and response capture
	always_ff @(posedge clock) begin
		if (state_q == ST_IDLE && req_valid_i) begin
			req_q <= req_i;
			err_q <= 1'b0;
		end
		if (r_fire) begin
			load_q <= load_word_i;
			err_q  <= (r_i.resp != RESP_OKAY);
		end
		if (b_fire)
			err_q <= (b_resp_i != RESP_OKAY);
	end

	assign req_o = req_q;

	// word aligned address on both address channels
	assign ar_o.addr = {req_q.addr[31:2], 2'b00};
	assign ar_o.size = SIZE_WORD;
	assign aw_o      = ar_o;
	assign w_o       = store_beat_i;

	assign ar_valid_o = (state_q == ST_ADDR) && is_load;
	assign aw_valid_o = (state_q == ST_ADDR) && is_store && !aw_done_q;
	assign w_valid_o  = (state_q == ST_ADDR) && is_store && !w_done_q;
	assign r_ready_o  = (state_q == ST_RESP) && is_load;
	assign b_ready_o  = (state_q == ST_RESP) && is_store;

	assign done_o = (state_q == ST_DONE);

	always_comb begin
		wb_o.rd     = req_q.rd;
		wb_o.is_mem = is_load || is_store;
		wb_o.err    = err_q;
		if (is_load)
			wb_o.wdata = load_q;
		else if (is_store)
			wb_o.wdata = '0;
		else
			wb_o.wdata = req_q.addr;
	end

endmodule

`default_nettype wire

/* verilog/store_align.sv */
`default_nettype none

module store_align
	import lsu_pkg::*, axi_lite_pkg::*;
(
	input  wire store_type_e store_type_i,
	input  wire logic [1:0]  offset_i,
	input  wire logic [31:0] data_i,
	output axi_wdata_t       beat_o
);

	logic [31:0] base_data;
	logic [3:0]  base_strb;

	// lane pattern before the offset shift
	always_comb begin
		case (store_type_i)
			STORE_SB: begin
				base_data = {4{data_i[7:0]}};
				base_strb = 4'h1;
			end
			STORE_SH: begin
				base_data = {2{data_i[15:0]}};
				base_strb = 4'h3;
			end
			STORE_SW: begin
				base_data = data_i;
				base_strb = 4'hf;
			end
			default: begin
				base_data = data_i;
				base_strb = 4'h0;
			end
		endcase
	end

	// strobe bits shifted past lane 3 fall off
	assign beat_o.data = base_data << {offset_i, 3'b000};
	assign beat_o.strb = base_strb << offset_i;

endmodule

`default_nettype wire

/* verilog/load_extend.sv */
`default_nettype none

module load_extend
	import lsu_pkg::*;
(
	input  wire load_type_e  load_type_i,
	input  wire logic [1:0]  offset_i,
	input  wire logic [31:0] word_i,
	output logic [31:0]      data_o
);

	logic [31:0] shifted;

	// addressed byte moves down to lane 0
	assign shifted = word_i >> {offset_i, 3'b000};

	always_comb begin
		case (load_type_i)
			LOAD_LB: begin
				data_o = {{24{shifted[7]}}, shifted[7:0]};
			end
			LOAD_LH: begin
				data_o = {{16{shifted[15]}}, shifted[15:0]};
			end
			LOAD_LBU: begin
				data_o = {24'h0, shifted[7:0]};
			end
			LOAD_LHU: begin
				data_o = {16'h0, shifted[15:0]};
			end
			default: begin
				data_o = shifted;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/axi_sram.sv */
`default_nettype none

module axi_sram
	import axi_lite_pkg::*;
#(
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_CYCLES = 2
) (
	input  wire logic       clock,
	input  wire logic       rstn,
	input  wire logic       ar_valid_i,
	input  wire axi_addr_t  ar_i,
	input  wire logic       aw_valid_i,
	input  wire axi_addr_t  aw_i,
	input  wire logic       w_valid_i,
	input  wire axi_wdata_t w_i,
	input  wire logic       r_ready_i,
	input  wire logic       b_ready_i,
	output logic            ar_ready_o,
	output logic            aw_ready_o,
	output logic            w_ready_o,
	output logic            r_valid_o,
	output axi_rdata_t      r_o,
	output logic            b_valid_o,
	output logic [1:0]      b_resp_o
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);
	localparam logic [CNT_W-1:0] WAIT_MAX  = CNT_W'(WAIT_CYCLES);
	// response needs at least one cycle after the handshake
	localparam logic [CNT_W-1:0] CNT_START = (WAIT_CYCLES == 0) ? '0 : CNT_W'(1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_WRITE
	} state_e;

	state_e           state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [31:0]      mem [MEM_WORDS];
	logic [31:0]      rdata_q;
	logic [1:0]       resp_q;
	logic             wr_req;
	logic             rd_in_range;
	logic             wr_in_range;
	logic             ar_fire;
	logic             wr_fire;

	assign wr_req      = aw_valid_i && w_valid_i;
	assign rd_in_range = ({2'b00, ar_i.addr[31:2]} < 32'(MEM_WORDS));
	assign wr_in_range = ({2'b00, aw_i.addr[31:2]} < 32'(MEM_WORDS));

	// reads take priority, aw and w are accepted together
	assign ar_ready_o = (state_q == S_IDLE) && ar_valid_i && (cnt_q == WAIT_MAX);
	assign aw_ready_o = (state_q == S_IDLE) && !ar_valid_i && wr_req && (cnt_q == WAIT_MAX);
	assign w_ready_o  = aw_ready_o;

	assign ar_fire = ar_valid_i && ar_ready_o;
	assign wr_fire = aw_ready_o;

	assign r_valid_o = (state_q == S_READ) && (cnt_q == WAIT_MAX);
	assign b_valid_o = (state_q == S_WRITE) && (cnt_q == WAIT_MAX);
	assign r_o.data  = rdata_q;
	assign r_o.resp  = resp_q;
	assign b_resp_o  = resp_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= S_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (ar_fire) begin
						state_q <= S_READ;
						cnt_q   <= CNT_START;
					end else if (wr_fire) begin
						state_q <= S_WRITE;
						cnt_q   <= CNT_START;
					end else if ((ar_valid_i || wr_req) && cnt_q != WAIT_MAX) begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				S_READ, S_WRITE: begin
					if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
						state_q <= S_IDLE;
						cnt_q   <= '0;
					end else if (cnt_q != WAIT_MAX) begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: begin
					state_q <= S_IDLE;
					cnt_q   <= '0;
				end
			endcase
		end
	end

	// word array, cleared on reset, byte masked writes
	always_ff @(posedge clock) begin
		if (!rstn) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end else if (wr_fire && wr_in_range) begin
			for (int b = 0; b < 4; b++) begin
				if (w_i.strb[b])
					mem[aw_i.addr[IDX_W+1:2]][8*b +: 8] <= w_i.data[8*b +: 8];
			end
		end
	end

	// response payload, out of range reads give zero
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rdata_q <= rd_in_range ? mem[ar_i.addr[IDX_W+1:2]] : '0;
			resp_q  <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end else if (wr_fire) begin
			resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
`default_nettype none

module lsu_top
	import lsu_pkg::*, axi_lite_pkg::*;
#(
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_CYCLES = 2
) (
	input  wire logic     clock,
	input  wire logic     rstn,
	input  wire logic     req_valid_i,
	input  wire lsu_req_t req_i,
	output logic          done_o,
	output lsu_wb_t       wb_o
);

	lsu_req_t    req_q;
	axi_wdata_t  store_beat;
	logic [31:0] load_word;

	// axi-lite channels
	logic       ar_valid;
	logic       ar_ready;
	axi_addr_t  ar;
	logic       aw_valid;
	logic       aw_ready;
	axi_addr_t  aw;
	logic       w_valid;
	logic       w_ready;
	axi_wdata_t w;
	logic       r_valid;
	logic       r_ready;
	axi_rdata_t r;
	logic       b_valid;
	logic       b_ready;
	logic [1:0] b_resp;

	lsu_ctrl lsu_ctrl_inst (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.store_beat_i (store_beat),
		.load_word_i  (load_word),
		.ar_ready_i   (ar_ready),
		.aw_ready_i   (aw_ready),
		.w_ready_i    (w_ready),
		.r_valid_i    (r_valid),
		.r_i          (r),
		.b_valid_i    (b_valid),
		.b_resp_i     (b_resp),
		.done_o       (done_o),
		.wb_o         (wb_o),
		.req_o        (req_q),
		.ar_valid_o   (ar_valid),
		.ar_o         (ar),
		.aw_valid_o   (aw_valid),
		.aw_o         (aw),
		.w_valid_o    (w_valid),
		.w_o          (w),
		.r_ready_o    (r_ready),
		.b_ready_o    (b_ready)
	);

	store_align store_align_inst (
		.store_type_i (req_q.store_type),
		.offset_i     (req_q.addr[1:0]),
		.data_i       (req_q.wdata),
		.beat_o       (store_beat)
	);

	load_extend load_extend_inst (
		.load_type_i (req_q.load_type),
		.offset_i    (req_q.addr[1:0]),
		.word_i      (r.data),
		.data_o      (load_word)
	);

	axi_sram #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_CYCLES (WAIT_CYCLES)
	) axi_sram_inst (
		.clock      (clock),
		.rstn       (rstn),
		.ar_valid_i (ar_valid),
		.ar_i       (ar),
		.aw_valid_i (aw_valid),
		.aw_i       (aw),
		.w_valid_i  (w_valid),
		.w_i        (w),
		.r_ready_i  (r_ready),
		.b_ready_i  (b_ready),
		.ar_ready_o (ar_ready),
		.aw_ready_o (aw_ready),
		.w_ready_o  (w_ready),
		.r_valid_o  (r_valid),
		.r_o        (r),
		.b_valid_o  (b_valid),
		.b_resp_o   (b_resp)
	);

endmodule

`default_nettype wire

/* verif/lsu_model.sv */
`default_nettype none

module lsu_model
	import lsu_pkg::*;
#(
	parameter int MEM_WORDS = 256
) ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IDX_W = $clog2(MEM_WORDS);

	// expected memory contents start at zero like the DUT after reset
	logic [31:0] mem [MEM_WORDS];

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	function automatic logic in_range(input logic [31:0] addr);
		return addr < 32'(MEM_WORDS * 4);
	endfunction

	// bytes moved by one store
	function automatic int store_bytes(input store_type_e kind);
		case (kind)
			STORE_SB: return 1;
			STORE_SH: return 2;
			STORE_SW: return 4;
			default: return 0;
		endcase
	endfunction

	// data byte j goes to lane offset+j and lanes past 3 drop off
	function automatic void apply_store(input logic [31:0] addr, input store_type_e kind,
			input logic [31:0] data);
		logic [IDX_W-1:0] idx;
		logic [2:0]       lane;
		logic [31:0]      word;
		int               nbytes;
		idx    = addr[IDX_W+1:2];
		nbytes = store_bytes(kind);
		if (in_range(addr)) begin
			word = mem[idx];
			for (int j = 0; j < 4; j++) begin
				lane = {1'b0, addr[1:0]} + 3'(j);
				if (j < nbytes && lane < 3'd4)
					word[{lane[1:0], 3'b000} +: 8] = data[8*j +: 8];
			end
			mem[idx] = word;
		end
	endfunction

	// lane offset+j becomes byte j before the load type sets width and sign
	function automatic logic [31:0] load_result(input logic [31:0] addr,
			input load_type_e kind);
		logic [IDX_W-1:0] idx;
		logic [2:0]       lane;
		logic [31:0]      word;
		logic [31:0]      picked;
		idx    = addr[IDX_W+1:2];
		picked = '0;
		if (!in_range(addr))
			return '0;
		word = mem[idx];
		for (int j = 0; j < 4; j++) begin
			lane = {1'b0, addr[1:0]} + 3'(j);
			if (lane < 3'd4)
				picked[8*j +: 8] = word[{lane[1:0], 3'b000} +: 8];
		end
		case (kind)
			LOAD_LB:  return {{24{picked[7]}}, picked[7:0]};
			LOAD_LH:  return {{16{picked[15]}}, picked[15:0]};
			LOAD_LBU: return {24'h0, picked[7:0]};
			LOAD_LHU: return {16'h0, picked[15:0]};
			default:  return picked;
		endcase
	endfunction

endmodule

`default_nettype wire

/* verif/lsu_tb.sv */
`default_nettype none

module lsu_tb
	import lsu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS   = 256;
	localparam int WAIT_CYCLES = 2;
	localparam int MEM_BYTES   = MEM_WORDS * 4;
	// cycle budget for the whole run
	localparam int MAX_CYCLES  = 600 * (4 * WAIT_CYCLES + 8);

	logic     clock;
	logic     rstn;
	logic     req_valid;
	lsu_req_t req;
	logic     done;
	lsu_wb_t  wb;

	int cycles = 0;
	int checks = 0;
	int errors = 0;

	lsu_top #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_CYCLES (WAIT_CYCLES)
	) lsu_top_inst (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid),
		.req_i       (req),
		.done_o      (done),
		.wb_o        (wb)
	);

	lsu_model #(
		.MEM_WORDS (MEM_WORDS)
	) model_inst ();

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic lsu_req_t make_request(input logic [31:0] addr, input logic [31:0] data,
			input load_type_e ld, input store_type_e st);
		lsu_req_t r;
		r.addr       = addr;
		r.wdata      = data;
		r.load_type  = ld;
		r.store_type = st;
		r.rd         = 5'($urandom);
		return r;
	endfunction

	function automatic logic [31:0] random_word_addr();
		return ($urandom % MEM_WORDS) * 4;
	endfunction

	function automatic load_type_e pick_sub_load(input int sel);
		case (sel % 4)
			0: return LOAD_LB;
			1: return LOAD_LH;
			2: return LOAD_LBU;
			default: return LOAD_LHU;
		endcase
	endfunction

	// one-cycle strobe on the falling edge
	task automatic pulse_request(input lsu_req_t r);
		@(negedge clock);
		req_valid = 1'b1;
		req       = r;
		@(negedge clock);
		req_valid = 1'b0;
	endtask

	task automatic wait_for_done(output lsu_wb_t result);
		while (done !== 1'b1)
			@(negedge clock);
		result = wb;
	endtask

	task automatic run_request(input lsu_req_t r, output lsu_wb_t result);
		pulse_request(r);
		wait_for_done(result);
	endtask

	task automatic check_wb(input lsu_wb_t got, input lsu_req_t r, input logic [31:0] exp_data,
			input logic exp_mem, input logic exp_err);
		checks++;
		if (got.wdata !== exp_data) begin
			$display("** Error: wb_o.wdata expected %h got %h (addr %h)",
				exp_data, got.wdata, r.addr);
			errors++;
		end
		if (got.rd !== r.rd) begin
			$display("** Error: wb_o.rd expected %h got %h", r.rd, got.rd);
			errors++;
		end
		if (got.is_mem !== exp_mem) begin
			$display("** Error: wb_o.is_mem expected %h got %h", exp_mem, got.is_mem);
			errors++;
		end
		if (got.err !== exp_err) begin
			$display("** Error: wb_o.err expected %h got %h (addr %h)", exp_err, got.err, r.addr);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int count, input int start_errors);
		$display("%-16s %0d requests, %0d errors", name, count, errors - start_errors);
	endtask

	initial begin
		lsu_req_t    r;
		lsu_wb_t     res;
		load_type_e  ld;
		store_type_e st;
		logic [31:0] base;
		logic [31:0] addr;
		int          start_errors;
		int          n;

		rstn      = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		void'($urandom(52));
		repeat (10) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// non-memory requests return the address after one cycle
		start_errors = errors;
		for (n = 0; n < 50; n++) begin
			r = make_request($urandom, $urandom, LOAD_NONE, STORE_NONE);
			@(negedge clock);
			req_valid = 1'b1;
			req       = r;
			@(negedge clock);
			req_valid = 1'b0;
			if (done !== 1'b1) begin
				$display("done_o did not rise one cycle after a non-memory request");
				errors++;
				wait_for_done(res);
			end else begin
				res = wb;
			end
			check_wb(res, r, r.addr, 1'b0, 1'b0);
		end
		report_test("passthrough", 50, start_errors);

		start_errors = errors;
		for (n = 0; n < 100; n++) begin
			addr = random_word_addr();
			r    = make_request(addr, $urandom, LOAD_NONE, STORE_SW);
			run_request(r, res);
			model_inst.apply_store(addr, STORE_SW, r.wdata);
			check_wb(res, r, 32'h0, 1'b1, 1'b0);
			r = make_request(addr, $urandom, LOAD_LW, STORE_NONE);
			run_request(r, res);
			check_wb(res, r, model_inst.load_result(addr, LOAD_LW), 1'b1, 1'b0);
		end
		report_test("word round trip", 200, start_errors);

		// offset walks through all four lanes
		start_errors = errors;
		for (n = 0; n < 150; n++) begin
			base = random_word_addr();
			addr = base + 32'(n % 4);
			st   = ($urandom % 2 == 0) ? STORE_SB : STORE_SH;
			r    = make_request(addr, $urandom, LOAD_NONE, st);
			run_request(r, res);
			model_inst.apply_store(addr, st, r.wdata);
			check_wb(res, r, 32'h0, 1'b1, 1'b0);
			r = make_request(base, $urandom, LOAD_LW, STORE_NONE);
			run_request(r, res);
			check_wb(res, r, model_inst.load_result(base, LOAD_LW), 1'b1, 1'b0);
		end
		report_test("sub-word stores", 300, start_errors);

		// fresh random word every fourth load
		start_errors = errors;
		base         = 32'h0;
		for (n = 0; n < 150; n++) begin
			if (n % 4 == 0) begin
				base = random_word_addr();
				r    = make_request(base, $urandom, LOAD_NONE, STORE_SW);
				run_request(r, res);
				model_inst.apply_store(base, STORE_SW, r.wdata);
				check_wb(res, r, 32'h0, 1'b1, 1'b0);
			end
			ld = pick_sub_load(int'($urandom % 4));
			if (ld == LOAD_LB || ld == LOAD_LBU)
				addr = base + ($urandom % 4);
			else
				addr = base + ($urandom % 2) * 2;
			r = make_request(addr, $urandom, ld, STORE_NONE);
			run_request(r, res);
			check_wb(res, r, model_inst.load_result(addr, ld), 1'b1, 1'b0);
		end
		report_test("sub-word loads", 188, start_errors);

		// first pass hits the first address past the end
		start_errors = errors;
		for (n = 0; n < 16; n++) begin
			addr = (n == 0) ? MEM_BYTES : $urandom;
			if (addr < MEM_BYTES)
				addr = addr + MEM_BYTES;
			r = make_request(addr, $urandom, LOAD_NONE, STORE_SW);
			run_request(r, res);
			model_inst.apply_store(addr, STORE_SW, r.wdata);
			check_wb(res, r, 32'h0, 1'b1, 1'b1);
			ld = (n % 2 == 0) ? LOAD_LW : pick_sub_load(n / 2);
			r  = make_request(addr, $urandom, ld, STORE_NONE);
			run_request(r, res);
			check_wb(res, r, 32'h0, 1'b1, 1'b1);
			// word that shares the low index bits must be untouched
			base = addr & 32'(MEM_BYTES - 4);
			r    = make_request(base, $urandom, LOAD_LW, STORE_NONE);
			run_request(r, res);
			check_wb(res, r, model_inst.load_result(base, LOAD_LW), 1'b1, 1'b0);
		end
		report_test("out of range", 48, start_errors);

		start_errors = errors;
		for (n = 0; n < 5; n++) begin
			addr = random_word_addr();
			r    = make_request(addr, $urandom, LOAD_NONE, STORE_SW);
			run_request(r, res);
			model_inst.apply_store(addr, STORE_SW, r.wdata);
			check_wb(res, r, 32'h0, 1'b1, 1'b0);
			r = make_request(addr, $urandom, LOAD_LW, STORE_NONE);
			pulse_request(r);
			// store strobe while the load waits on the memory
			@(negedge clock);
			req_valid = 1'b1;
			req       = make_request(addr, ~r.wdata, LOAD_NONE, STORE_SW);
			@(negedge clock);
			req_valid = 1'b0;
			wait_for_done(res);
			check_wb(res, r, model_inst.load_result(addr, LOAD_LW), 1'b1, 1'b0);
			repeat (4 * WAIT_CYCLES + 8) begin
				@(negedge clock);
				if (done === 1'b1) begin
					$display("done_o pulsed again after a strobe sent while the unit was busy");
					errors++;
				end
			end
			r = make_request(addr, $urandom, LOAD_LW, STORE_NONE);
			run_request(r, res);
			check_wb(res, r, model_inst.load_result(addr, LOAD_LW), 1'b1, 1'b0);
		end
		report_test("ignored strobe", 15, start_errors);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/lsu_pkg.sv
verilog/axi_lite_pkg.sv
verilog/lsu_ctrl.sv
verilog/store_align.sv
verilog/load_extend.sv
verilog/axi_sram.sv
verilog/lsu_top.sv
verif/lsu_model.sv
verif/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the lsu testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module lsu_tb -o lsu_sim &&
./obj_dir/lsu_sim | tee /dev/stderr | grep -qx "Test OK" &&
echo "run.sh: simulation passed" ||
{
	echo "run.sh: simulation failed"
	exit 1
}
